//--- source/lsu_pkg.sv
// load/store unit shared definitions
// widths, funct3 access codes, MMIO map and address decode bit

package lsu_pkg;

    // ------------------------------
    // widths
    // ------------------------------

    // data and address width
    localparam int XLEN  = 32;
    // bytes per word, one enable per lane
    localparam int BYTES = XLEN / 8;

    // ------------------------------
    // access codes
    // ------------------------------

    // same encoding as RISC-V load/store funct3
    typedef logic [2:0] mem_size_t;

    localparam mem_size_t SIZE_B  = 3'd0;
    localparam mem_size_t SIZE_H  = 3'd1;
    localparam mem_size_t SIZE_W  = 3'd2;
    localparam mem_size_t SIZE_BU = 3'd4;
    localparam mem_size_t SIZE_HU = 3'd5;

    // ------------------------------
    // address map
    // ------------------------------

    // set selects MMIO, clear selects data memory
    localparam int MMIO_SEL_BIT = 31;

    // MMIO word index comes from address bits 4..2
    typedef logic [2:0] mmio_idx_t;

    // write side
    localparam mmio_idx_t MMIO_UART_TX     = 3'd0;
    localparam mmio_idx_t MMIO_CNT_RESET   = 3'd4;

    // read side
    localparam mmio_idx_t MMIO_UART_STATUS = 3'd0;
    localparam mmio_idx_t MMIO_UART_RX     = 3'd1;
    localparam mmio_idx_t MMIO_CYCLE_CNT   = 3'd5;
    localparam mmio_idx_t MMIO_INSTR_CNT   = 3'd6;

endpackage

//--- source/lsu_bus_slave.sv
// Wishbone classic slave front end
// takes one request at a time, registers it and fires a single access pulse

module lsu_bus_slave import lsu_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [XLEN-1:0]  wb_adr,
    input  logic [XLEN-1:0]  wb_dat_w,
    input  mem_size_t        wb_size,
    input  logic             wb_ack,
    output logic             access,
    output logic             acc_write,
    output logic [XLEN-1:0]  acc_addr,
    output logic [XLEN-1:0]  acc_wdata,
    output mem_size_t        acc_size
);

    // request in flight, held until its ack cycle is over
    logic busy;
    logic accept;

    // new request only when idle and not inside an ack cycle
    assign accept = wb_cyc && wb_stb && !busy && !wb_ack;

    // ------------------------------
    // control
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            access <= 1'b0;
        end else begin
            // one cycle strobe towards the data space
            access <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (wb_ack) begin
                busy <= 1'b0;
            end
        end
    end

    // ------------------------------
    // request fields
    // ------------------------------

    // held for the whole transaction, load align reads addr and size late
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_write <= wb_we;
            acc_addr  <= wb_adr;
            acc_wdata <= wb_dat_w;
            acc_size  <= wb_size;
        end
    end

endmodule

//--- source/lsu_store_align.sv
// store alignment
// moves store data into its byte lanes and builds the byte enable mask

module lsu_store_align import lsu_pkg::*; (
    input  logic             acc_write,
    input  logic [XLEN-1:0]  acc_addr,
    input  logic [XLEN-1:0]  acc_wdata,
    input  mem_size_t        acc_size,
    output logic [XLEN-1:0]  lane_data,
    output logic [BYTES-1:0] byte_en
);

    // byte offset inside the word
    logic [1:0]       offset;
    // enables before the offset shift
    logic [BYTES-1:0] size_mask;

    assign offset = acc_addr[1:0];

    // offset in bytes -> shift in bits
    assign lane_data = acc_wdata << {offset, 3'b000};

    // one, two or four lanes from the size
    always_comb begin
        case (acc_size)
            SIZE_B, SIZE_BU: begin
                size_mask = BYTES'(4'b0001);
            end
            SIZE_H, SIZE_HU: begin
                size_mask = BYTES'(4'b0011);
            end
            SIZE_W: begin
                size_mask = '1;
            end
            default: begin
                // unused codes treated as a full word
                size_mask = '1;
            end
        endcase
    end

    // loads never write, so all lanes stay off
    assign byte_en = acc_write ? (size_mask << offset) : '0;

endmodule

//--- source/lsu_data_space.sv
// data memory space
// decodes bit 31 between the data memory and the MMIO registers

module lsu_data_space import lsu_pkg::*; #(
    parameter int DMEM_WORDS = 1024
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             access,
    input  logic [XLEN-1:0]  acc_addr,
    input  logic [XLEN-1:0]  lane_data,
    input  logic [BYTES-1:0] byte_en,
    input  logic [7:0]       uart_rx_data,
    input  logic             uart_rx_valid,
    input  logic             uart_tx_ready,
    input  logic [XLEN-1:0]  cycle_cnt,
    input  logic [XLEN-1:0]  instr_cnt,
    output logic [XLEN-1:0]  rdata,
    output logic             done,
    output logic [7:0]       uart_tx_data,
    output logic             cnt_reset
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [XLEN-1:0]  mem [DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    mmio_idx_t        mmio_idx;
    logic             mmio_sel;
    logic             dmem_acc;
    logic             mmio_acc;
    logic [XLEN-1:0]  dmem_rdata;
    logic [XLEN-1:0]  mmio_rdata;
    // which side answered the last access
    logic             mmio_sel_q;

    // ------------------------------
    // decode
    // ------------------------------

    assign mmio_sel = acc_addr[MMIO_SEL_BIT];
    assign word_idx = acc_addr[IDX_W+1:2];
    assign mmio_idx = acc_addr[4:2];
    assign dmem_acc = access && !mmio_sel;
    assign mmio_acc = access && mmio_sel;

    // ------------------------------
    // data memory
    // ------------------------------

    // byte masked write, synchronous read of the old word
    always_ff @(posedge clk) begin
        if (dmem_acc) begin
            for (int i = 0; i < BYTES; i++) begin
                if (byte_en[i]) begin
                    mem[word_idx][i*8 +: 8] <= lane_data[i*8 +: 8];
                end
            end
            dmem_rdata <= mem[word_idx];
        end
    end

    // ------------------------------
    // MMIO
    // ------------------------------

    // write registers, lane 0 must be enabled
    always_ff @(posedge clk) begin
        if (rst) begin
            uart_tx_data <= 8'd0;
            cnt_reset    <= 1'b0;
        end else if (mmio_acc && byte_en[0]) begin
            case (mmio_idx)
                MMIO_UART_TX:   uart_tx_data <= lane_data[7:0];
                MMIO_CNT_RESET: cnt_reset    <= lane_data[0];
                default:        ;
            endcase
        end
    end

    // read side, sampled at the same edge as the memory
    always_ff @(posedge clk) begin
        if (mmio_acc) begin
            case (mmio_idx)
                MMIO_UART_STATUS: mmio_rdata <= {{(XLEN-2){1'b0}}, uart_rx_valid, uart_tx_ready};
                MMIO_UART_RX:     mmio_rdata <= {{(XLEN-8){1'b0}}, uart_rx_data};
                MMIO_CYCLE_CNT:   mmio_rdata <= cycle_cnt;
                MMIO_INSTR_CNT:   mmio_rdata <= instr_cnt;
                default:          mmio_rdata <= '0;
            endcase
        end
    end

    // done one cycle behind access
    always_ff @(posedge clk) begin
        if (rst) begin
            done       <= 1'b0;
            mmio_sel_q <= 1'b0;
        end else begin
            done <= access;
            if (access) begin
                mmio_sel_q <= mmio_sel;
            end
        end
    end

    assign rdata = mmio_sel_q ? mmio_rdata : dmem_rdata;

endmodule

//--- source/lsu_load_align.sv
// load alignment and bus response
// shift, mask and extend the read word, register it with the ack

module lsu_load_align import lsu_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             done,
    input  logic [XLEN-1:0]  acc_addr,
    input  mem_size_t        acc_size,
    input  logic [XLEN-1:0]  rdata,
    output logic [XLEN-1:0]  wb_dat_r,
    output logic             wb_ack
);

    // addressed byte moved down to lane 0
    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] load_val;

    assign shifted = rdata >> {acc_addr[1:0], 3'b000};

    // keep byte, half or word
    // signed codes copy the top kept bit upwards
    always_comb begin
        case (acc_size)
            SIZE_B:  load_val = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            SIZE_H:  load_val = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            SIZE_BU: load_val = {{(XLEN-8){1'b0}}, shifted[7:0]};
            SIZE_HU: load_val = {{(XLEN-16){1'b0}}, shifted[15:0]};
            default: load_val = shifted;
        endcase
    end

    // ------------------------------
    // response
    // ------------------------------

    // single cycle ack per request
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= done;
        end
    end

    // store responses carry whatever was read, master ignores them
    always_ff @(posedge clk) begin
        if (done) begin
            wb_dat_r <= load_val;
        end
    end

endmodule

//--- source/lsu_top.sv
// load/store unit top level
// Wishbone slave -> store align -> data space -> load align

module lsu_top import lsu_pkg::*; #(
    parameter int DMEM_WORDS = 1024
) (
    input  logic             clk,
    input  logic             rst,
    // bus
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [XLEN-1:0]  wb_adr,
    input  logic [XLEN-1:0]  wb_dat_w,
    input  mem_size_t        wb_size,
    output logic [XLEN-1:0]  wb_dat_r,
    output logic             wb_ack,
    // MMIO
    input  logic [7:0]       uart_rx_data,
    input  logic             uart_rx_valid,
    input  logic             uart_tx_ready,
    input  logic [XLEN-1:0]  cycle_cnt,
    input  logic [XLEN-1:0]  instr_cnt,
    output logic [7:0]       uart_tx_data,
    output logic             cnt_reset
);

    // ------------------------------
    // internal path
    // ------------------------------

    logic             access;
    logic             acc_write;
    logic [XLEN-1:0]  acc_addr;
    logic [XLEN-1:0]  acc_wdata;
    mem_size_t        acc_size;
    logic [XLEN-1:0]  lane_data;
    logic [BYTES-1:0] byte_en;
    logic [XLEN-1:0]  rdata;
    logic             done;

    // input side
    lsu_bus_slave lsu_bus_slave_i (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_size   (wb_size),
        .wb_ack    (wb_ack),
        .access    (access),
        .acc_write (acc_write),
        .acc_addr  (acc_addr),
        .acc_wdata (acc_wdata),
        .acc_size  (acc_size)
    );

    lsu_store_align lsu_store_align_i (
        .acc_write (acc_write),
        .acc_addr  (acc_addr),
        .acc_wdata (acc_wdata),
        .acc_size  (acc_size),
        .lane_data (lane_data),
        .byte_en   (byte_en)
    );

    lsu_data_space #(
        .DMEM_WORDS (DMEM_WORDS)
    ) lsu_data_space_i (
        .clk           (clk),
        .rst           (rst),
        .access        (access),
        .acc_addr      (acc_addr),
        .lane_data     (lane_data),
        .byte_en       (byte_en),
        .uart_rx_data  (uart_rx_data),
        .uart_rx_valid (uart_rx_valid),
        .uart_tx_ready (uart_tx_ready),
        .cycle_cnt     (cycle_cnt),
        .instr_cnt     (instr_cnt),
        .rdata         (rdata),
        .done          (done),
        .uart_tx_data  (uart_tx_data),
        .cnt_reset     (cnt_reset)
    );

    // output side
    lsu_load_align lsu_load_align_i (
        .clk      (clk),
        .rst      (rst),
        .done     (done),
        .acc_addr (acc_addr),
        .acc_size (acc_size),
        .rdata    (rdata),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

//--- verification/lsu_clk_gen.sv
// clock and reset source for the load/store unit testbench
// period 4, reset held high over the first three rising edges

module lsu_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        // release lines up with the stimulus drive point
        #1 rst = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

//--- verification/lsu_monitor.sv
// bus and MMIO monitor for the load/store unit
// shadow memory, load reference model and comparison on every ack

module lsu_monitor import lsu_pkg::*; #(
    parameter int DMEM_WORDS = 1024
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            wb_cyc,
    input  logic            wb_stb,
    input  logic            wb_we,
    input  logic [XLEN-1:0] wb_adr,
    input  logic [XLEN-1:0] wb_dat_w,
    input  mem_size_t       wb_size,
    input  logic [XLEN-1:0] wb_dat_r,
    input  logic            wb_ack,
    input  logic [7:0]      uart_rx_data,
    input  logic            uart_rx_valid,
    input  logic            uart_tx_ready,
    input  logic [XLEN-1:0] cycle_cnt,
    input  logic [XLEN-1:0] instr_cnt,
    input  logic [7:0]      uart_tx_data,
    input  logic            cnt_reset,
    output int              err_count,
    output int              load_count,
    output int              req_count
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] shadow [DMEM_WORDS];
    // request captured while waiting for its ack
    logic            pending;
    logic            p_we;
    logic [XLEN-1:0] p_adr;
    logic [XLEN-1:0] p_dat;
    mem_size_t       p_size;
    // expected MMIO write registers
    logic [7:0]      exp_tx;
    logic            exp_cnt;

    // ------------------------------
    // reference model
    // ------------------------------

    // byte, half or word picked out of the addressed word, then extended
    function automatic logic [XLEN-1:0] ref_load(input logic [XLEN-1:0] word,
                                                 input logic [1:0] off,
                                                 input mem_size_t size);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (size)
            SIZE_B:  return {{24{b[7]}}, b};
            SIZE_BU: return {24'd0, b};
            SIZE_H:  return {{16{h[15]}}, h};
            SIZE_HU: return {16'd0, h};
            default: return word;
        endcase
    endfunction

    // MMIO read map
    function automatic logic [XLEN-1:0] mmio_word(input logic [2:0] idx);
        case (idx)
            3'd0:    return {30'd0, uart_rx_valid, uart_tx_ready};
            3'd1:    return {24'd0, uart_rx_data};
            3'd5:    return cycle_cnt;
            3'd6:    return instr_cnt;
            default: return '0;
        endcase
    endfunction

    // store effect on the shadow word or the MMIO write registers
    task automatic apply_store();
        int nbytes;
        logic [1:0] off;
        off = p_adr[1:0];
        if (p_size == SIZE_B || p_size == SIZE_BU) begin
            nbytes = 1;
        end else if (p_size == SIZE_H || p_size == SIZE_HU) begin
            nbytes = 2;
        end else begin
            nbytes = 4;
        end
        if (p_adr[MMIO_SEL_BIT]) begin
            // only writes that cover byte 0 reach the registers
            if (off == 2'd0 && p_adr[4:2] == 3'd0) begin
                exp_tx = p_dat[7:0];
            end else if (off == 2'd0 && p_adr[4:2] == 3'd4) begin
                exp_cnt = p_dat[0];
            end
        end else begin
            for (int i = 0; i < nbytes; i++) begin
                shadow[p_adr[IDX_W+1:2]][8*(off+i) +: 8] = p_dat[8*i +: 8];
            end
        end
    endtask

    // ------------------------------
    // compare
    // ------------------------------

    // sampled mid cycle, inputs change just after the rising edge
    always @(negedge clk) begin
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] exp;
        if (rst) begin
            pending = 1'b0;
            exp_tx  = 8'd0;
            exp_cnt = 1'b0;
        end else if (wb_ack && !pending) begin
            err_count++;
            $display("ack seen at %0t with no request outstanding", $time);
        end else if (wb_ack) begin
            word = p_adr[MMIO_SEL_BIT] ? mmio_word(p_adr[4:2]) : shadow[p_adr[IDX_W+1:2]];
            if (p_we) begin
                apply_store();
            end else begin
                exp = ref_load(word, p_adr[1:0], p_size);
                load_count++;
                if (wb_dat_r !== exp) begin
                    err_count++;
                    $display("FAIL %0t: wb_dat_r expected %h got %h (adr %h size %0d)",
                             $time, exp, wb_dat_r, p_adr, p_size);
                end
            end
            if (uart_tx_data !== exp_tx) begin
                err_count++;
                $display("FAIL %0t: uart_tx_data expected %h got %h", $time, exp_tx, uart_tx_data);
            end
            if (cnt_reset !== exp_cnt) begin
                err_count++;
                $display("FAIL %0t: cnt_reset expected %b got %b", $time, exp_cnt, cnt_reset);
            end
            pending = 1'b0;
        end else if (!pending && wb_cyc && wb_stb) begin
            // new request, held by the master until its ack
            p_we    = wb_we;
            p_adr   = wb_adr;
            p_dat   = wb_dat_w;
            p_size  = wb_size;
            pending = 1'b1;
            req_count++;
        end
    end

endmodule

//--- verification/lsu_chk.sv
// Wishbone protocol and alignment assertions
// bound to the load/store unit top level

module lsu_chk import lsu_pkg::*; (
    input logic            clk,
    input logic            rst,
    input logic            wb_cyc,
    input logic            wb_stb,
    input logic [XLEN-1:0] wb_adr,
    input mem_size_t       wb_size,
    input logic            wb_ack
);

    // assertion failures seen so far
    int   fails;
    logic pend;
    logic accept_seen;

    // request taken at this edge
    assign accept_seen = wb_cyc && wb_stb && !pend && !wb_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= 1'b0;
        end else if (accept_seen) begin
            pend <= 1'b1;
        end else if (wb_ack) begin
            pend <= 1'b0;
        end
    end

    // ------------------------------
    // protocol
    // ------------------------------

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            fails++;
            $error("ack outside an active cycle");
        end

    ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else begin
            fails++;
            $error("ack high two cycles running");
        end

    // fixed latency of three edges
    ack_latency: assert property (@(posedge clk) disable iff (rst)
        accept_seen |-> ##3 wb_ack)
        else begin
            fails++;
            $error("ack not three cycles after acceptance");
        end

    // ------------------------------
    // alignment
    // ------------------------------

    half_aligned: assert property (@(posedge clk) disable iff (rst)
        (accept_seen && (wb_size == SIZE_H || wb_size == SIZE_HU)) |-> !wb_adr[0])
        else begin
            fails++;
            $error("misaligned halfword access");
        end

    word_aligned: assert property (@(posedge clk) disable iff (rst)
        (accept_seen && wb_size == SIZE_W) |-> (wb_adr[1:0] == 2'b00))
        else begin
            fails++;
            $error("misaligned word access");
        end

endmodule

bind lsu_top lsu_chk lsu_chk_i (
    .clk     (clk),
    .rst     (rst),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_adr  (wb_adr),
    .wb_size (wb_size),
    .wb_ack  (wb_ack)
);

//--- verification/lsu_tb.sv
// load/store unit testbench
// directed data memory and MMIO cases, then a random aligned mix

module lsu_tb import lsu_pkg::*; ();

    localparam int DMEM_WORDS = 1024;
    // words 0..31 hold the fill pattern and take the random traffic
    localparam int N_FILL     = 32;
    localparam int N_DIRECTED = 35;
    localparam int N_RAND     = 200;
    localparam int N_REQ      = 2 * N_FILL + N_DIRECTED + N_RAND;
    localparam int TIMEOUT    = N_REQ * 8 + 100;

    logic            clk;
    logic            rst;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    logic [XLEN-1:0] wb_adr;
    logic [XLEN-1:0] wb_dat_w;
    mem_size_t       wb_size;
    logic [XLEN-1:0] wb_dat_r;
    logic            wb_ack;
    logic [7:0]      uart_rx_data;
    logic            uart_rx_valid;
    logic            uart_tx_ready;
    logic [XLEN-1:0] cycle_cnt;
    logic [XLEN-1:0] instr_cnt;
    logic [7:0]      uart_tx_data;
    logic            cnt_reset;
    int              err_count;
    int              load_count;
    int              req_count;
    int              issued;
    logic [31:0]     seed;

    lsu_clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    lsu_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) lsu_top_i (
        .clk (clk), .rst (rst),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_size (wb_size), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .uart_rx_data (uart_rx_data), .uart_rx_valid (uart_rx_valid),
        .uart_tx_ready (uart_tx_ready), .cycle_cnt (cycle_cnt), .instr_cnt (instr_cnt),
        .uart_tx_data (uart_tx_data), .cnt_reset (cnt_reset)
    );

    lsu_monitor #(
        .DMEM_WORDS (DMEM_WORDS)
    ) monitor_i (
        .clk (clk), .rst (rst),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_size (wb_size), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .uart_rx_data (uart_rx_data), .uart_rx_valid (uart_rx_valid),
        .uart_tx_ready (uart_tx_ready), .cycle_cnt (cycle_cnt), .instr_cnt (instr_cnt),
        .uart_tx_data (uart_tx_data), .cnt_reset (cnt_reset),
        .err_count (err_count), .load_count (load_count), .req_count (req_count)
    );

    // ------------------------------
    // helpers
    // ------------------------------

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // initial memory contents, a function of the full address
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h0100_0193) ^ 32'hc3a5_5a3c;
    endfunction

    function automatic mem_size_t size_from(input logic [2:0] k);
        case (k)
            3'd0:    return SIZE_B;
            3'd1:    return SIZE_H;
            3'd3:    return SIZE_BU;
            3'd4:    return SIZE_HU;
            default: return SIZE_W;
        endcase
    endfunction

    // natural alignment for the access size
    function automatic logic [1:0] align_off(input mem_size_t sz, input logic [1:0] off);
        if (sz == SIZE_B || sz == SIZE_BU) begin
            return off;
        end else if (sz == SIZE_H || sz == SIZE_HU) begin
            return {off[1], 1'b0};
        end
        return 2'b00;
    endfunction

    task automatic set_mmio(input logic [7:0] rx, input logic rx_v, input logic tx_r,
                            input logic [31:0] cyc_n, input logic [31:0] ins_n);
        uart_rx_data  = rx;
        uart_rx_valid = rx_v;
        uart_tx_ready = tx_r;
        cycle_cnt     = cyc_n;
        instr_cnt     = ins_n;
    endtask

    // one classic cycle, called and returning 1 after a rising edge
    task automatic bus_xfer(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            input mem_size_t size);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_size  = size;
        issued++;
        do @(negedge clk); while (!wb_ack);
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] d;
        logic [1:0]  off;
        mem_size_t   sz;
        int          tb_errs;
        int          total;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_size = SIZE_W;
        set_mmio(8'd0, 1'b0, 1'b0, 32'd0, 32'd0);
        seed = 32'h7e9b6c7f;
        tb_errs = 0;
        wait (rst === 1'b0);
        @(posedge clk);
        #1;
        // word writes then read back
        for (int i = 0; i < N_FILL; i++) begin
            bus_xfer(1'b1, 32'(i * 4), fill_word(32'(i * 4)), SIZE_W);
        end
        for (int i = 0; i < N_FILL; i++) begin
            bus_xfer(1'b0, 32'(i * 4), 32'd0, SIZE_W);
        end
        // byte and half lanes, each followed by a word load
        for (int i = 0; i < 4; i++) begin
            seed = lcg(seed);
            bus_xfer(1'b1, 32'h10 + 32'(i), seed, SIZE_B);
            bus_xfer(1'b0, 32'h10, 32'd0, SIZE_W);
        end
        for (int i = 0; i < 4; i += 2) begin
            seed = lcg(seed);
            bus_xfer(1'b1, 32'h14 + 32'(i), seed, SIZE_H);
            bus_xfer(1'b0, 32'h14, 32'd0, SIZE_W);
        end
        // every byte and half has its top bit set
        bus_xfer(1'b1, 32'h18, 32'hf1e2_d3c4, SIZE_W);
        for (int i = 0; i < 4; i++) begin
            bus_xfer(1'b0, 32'h18 + 32'(i), 32'd0, SIZE_B);
            bus_xfer(1'b0, 32'h18 + 32'(i), 32'd0, SIZE_BU);
        end
        for (int i = 0; i < 4; i += 2) begin
            bus_xfer(1'b0, 32'h18 + 32'(i), 32'd0, SIZE_H);
            bus_xfer(1'b0, 32'h18 + 32'(i), 32'd0, SIZE_HU);
        end
        // MMIO writes, memory words 0 and 4 must keep their data
        bus_xfer(1'b1, 32'h8000_0000, 32'hc0ff_ee5a, SIZE_B);
        bus_xfer(1'b1, 32'h8000_0010, 32'h0000_0001, SIZE_W);
        bus_xfer(1'b0, 32'h0000_0000, 32'd0, SIZE_W);
        bus_xfer(1'b0, 32'h0000_0010, 32'd0, SIZE_W);
        // MMIO reads incl. unused offsets 3 and 7
        set_mmio(8'ha7, 1'b1, 1'b0, 32'h1234_5678, 32'h9abc_def0);
        for (int k = 0; k < 8; k++) begin
            if (k != 2 && k != 4) begin
                bus_xfer(1'b0, {1'b1, 26'd0, 3'(k), 2'b00}, 32'd0, SIZE_W);
            end
        end
        // random aligned mix over both spaces
        for (int n = 0; n < N_RAND; n++) begin
            seed = lcg(seed);
            r = seed;
            seed = lcg(seed);
            d = seed;
            set_mmio(d[7:0], d[8], d[9], lcg(d), ~d);
            sz = size_from(r[6:4]);
            off = align_off(sz, r[9:8]);
            if (r[1:0] == 2'b00) begin
                bus_xfer(r[3], {1'b1, 26'd0, r[12:10], off}, d, sz);
            end else begin
                bus_xfer(r[3], {25'd0, r[15:11], off}, d, sz);
            end
        end
        repeat (4) @(posedge clk);
        if (req_count != issued) begin
            tb_errs++;
            $display("monitor saw %0d requests but %0d were issued", req_count, issued);
        end
        total = err_count + lsu_top_i.lsu_chk_i.fails + tb_errs;
        $display("errors %0d (compare %0d, assertion %0d, count %0d), loads %0d, requests %0d",
                 total, err_count, lsu_top_i.lsu_chk_i.fails, tb_errs, load_count, issued);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog sized from the request count
    initial begin : watchdog
        repeat (TIMEOUT) @(posedge clk);
        $display("timeout after %0d cycles, a bus cycle never got its ack", TIMEOUT);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- sim.f
source/lsu_pkg.sv
source/lsu_bus_slave.sv
source/lsu_store_align.sv
source/lsu_data_space.sv
source/lsu_load_align.sv
source/lsu_top.sv
verification/lsu_clk_gen.sv
verification/lsu_monitor.sv
verification/lsu_chk.sv
verification/lsu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the load/store unit testbench with Verilator, run it, judge by the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module lsu_tb -f sim.f -o lsu_sim \
    && ./obj_dir/lsu_sim +verilator+error+limit+1000 2>&1 | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -q "^SIMULATION PASSED$" sim.log \
    && { echo "run ok"; exit 0; } \
    || { echo "run failed, see sim.log"; exit 1; }
